//--- Makefile
# Verilator build and run of the rename slice testbench

VERILATOR ?= verilator
TOP       ?= tb_rename_unit
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: compile
	./$(BINARY) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rat_entry.sv
// One architectural register in the alias table, instantiated per register by reg_alias_table
`timescale 1ns/100ps
`default_nettype none

module rat_entry (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_flush,
    input  logic                     i_rename_en,
    input  rename_cfg_pkg::rob_tag_t i_rename_tag,
    input  logic                     i_retire_en,
    input  rename_cfg_pkg::rob_tag_t i_retire_tag,
    input  rename_cfg_pkg::data_t    i_retire_data,
    output rename_cfg_pkg::data_t    o_data,
    output rename_cfg_pkg::rob_tag_t o_tag,
    output logic                     o_rdy
);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_data <= '0;
            o_tag  <= '0;
            o_rdy  <= 1'b1;
        end else begin
            // The committed value is always updated, even if a newer producer is in flight
            if (i_retire_en) begin
                o_data <= i_retire_data;
            end

            // A same-cycle rename keeps the entry waiting on its newer tag
            if (i_flush) begin
                o_rdy <= 1'b1;
            end else if (i_rename_en) begin
                o_tag <= i_rename_tag;
                o_rdy <= 1'b0;
            end else if (i_retire_en && (o_tag == i_retire_tag)) begin
                o_rdy <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- reg_alias_table.sv
// Register alias table mapping each architectural register to its value or its newest ROB tag
`timescale 1ns/100ps
`default_nettype none

module reg_alias_table (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_flush,
    input  rename_bus_pkg::decoded_t           i_decoded,
    input  logic                               i_rename_en,
    input  rename_cfg_pkg::rob_tag_t           i_rename_tag,
    input  rename_bus_pkg::retire_t            i_retire,
    output rename_bus_pkg::rat_lookup_t [1:0]  o_lookup
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    logic [ARCH_REGS-1:0] rename_sel;
    logic [ARCH_REGS-1:0] retire_sel;
    data_t                entry_data [ARCH_REGS];
    rob_tag_t             entry_tag  [ARCH_REGS];
    logic [ARCH_REGS-1:0] entry_rdy;
    reg_idx_t             src_idx    [2];

    // One-hot write selects for the destination and the retiring register
    assign rename_sel = i_rename_en ? (ARCH_REGS'(1) << i_decoded.rd) : '0;
    assign retire_sel = i_retire.valid ? (ARCH_REGS'(1) << i_retire.rd) : '0;

    // x0 has no storage and always reads ready and zero
    assign entry_data[0] = '0;
    assign entry_tag[0]  = '0;
    assign entry_rdy[0]  = 1'b1;

    for (genvar r = 1; r < ARCH_REGS; r++) begin : g_entry
        rat_entry rat_entry_i (
            .clk           (clk),
            .i_rst         (i_rst),
            .i_flush       (i_flush),
            .i_rename_en   (rename_sel[r]),
            .i_rename_tag  (i_rename_tag),
            .i_retire_en   (retire_sel[r]),
            .i_retire_tag  (i_retire.tag),
            .i_retire_data (i_retire.data),
            .o_data        (entry_data[r]),
            .o_tag         (entry_tag[r]),
            .o_rdy         (entry_rdy[r])
        );
    end

    assign src_idx[0] = i_decoded.rs1;
    assign src_idx[1] = i_decoded.rs2;

    // A producer retiring this cycle has not reached its entry yet, so its data is
    // taken straight from the retire bus when the entry still waits on that tag
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            logic     bypass;
            reg_idx_t src;

            src    = src_idx[i];
            bypass = i_retire.valid && !entry_rdy[src] &&
                     (entry_tag[src] == i_retire.tag) && (i_retire.rd == src);

            o_lookup[i].rdy  = entry_rdy[src] || bypass;
            o_lookup[i].data = bypass ? i_retire.data : entry_data[src];
            o_lookup[i].tag  = entry_tag[src];
        end
    end

    // x0 is filtered out by the decoder, so neither port may ever select it
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (i_rst)
        !rename_sel[0] && !retire_sel[0]
    ) else $error("alias table write selected x0");

endmodule

`default_nettype wire

//--- rename_bus_pkg.sv
// Packed structs carried between decoder, alias table, reorder buffer and the top-level ports
`default_nettype none

package rename_bus_pkg;

    import rename_cfg_pkg::*;

    // Register fields of one instruction, unused sources forced to x0
    typedef struct packed {
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     writes_rd;
    } decoded_t;

    // One source as held in the alias table
    typedef struct packed {
        logic     rdy;
        data_t    data;
        rob_tag_t tag;
    } rat_lookup_t;

    // Source after the reorder buffer has had a chance to forward a completed value
    typedef struct packed {
        logic     rdy;
        data_t    data;
        rob_tag_t tag;
    } operand_t;

    typedef struct packed {
        rob_tag_t       tag;
        reg_idx_t       rd;
        logic           writes_rd;
        operand_t [1:0] src;
    } dispatch_t;

    // Result broadcast from an execution unit
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    data;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        rob_tag_t tag;
        data_t    data;
    } retire_t;

endpackage

`default_nettype wire

//--- rename_cfg_pkg.sv
// Core sizing constants, opcode values and plain vector types, imported by every design file
`default_nettype none

package rename_cfg_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ARCH_REGS     = 32;
    localparam int ROB_DEPTH     = 8;
    localparam int REG_IDX_WIDTH = $clog2(ARCH_REGS);
    localparam int ROB_TAG_WIDTH = $clog2(ROB_DEPTH);

    // One extra bit so the occupancy count can reach ROB_DEPTH
    localparam int ROB_CNT_WIDTH = ROB_TAG_WIDTH + 1;

    // RV32I major opcodes recognised by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;
    typedef logic [ROB_CNT_WIDTH-1:0] rob_cnt_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [31:0]              instr_t;

endpackage

`default_nettype wire

//--- rename_decoder.sv
// Combinational decode of a 32-bit instruction into the register fields used by rename
`timescale 1ns/100ps
`default_nettype none

module rename_decoder (
    input  rename_cfg_pkg::instr_t   i_instr,
    output rename_bus_pkg::decoded_t o_decoded,
    output logic                     o_illegal
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    logic [6:0] opcode;
    logic       use_rs1;
    logic       use_rs2;
    logic       use_rd;
    reg_idx_t   rd;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];

    // Which register fields each instruction class actually uses
    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_rd    = 1'b0;
        o_illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                use_rd = 1'b1;
            end
            default: begin
                o_illegal = 1'b1;
            end
        endcase
    end

    // Unused sources read as x0, which the alias table always reports ready
    assign o_decoded.rs1 = use_rs1 ? i_instr[19:15] : '0;
    assign o_decoded.rs2 = use_rs2 ? i_instr[24:20] : '0;
    assign o_decoded.rd  = use_rd ? rd : '0;

    // Writes to x0 are dropped here so x0 is never renamed
    assign o_decoded.writes_rd = use_rd && (rd != '0);

endmodule

`default_nettype wire

//--- rename_unit.sv
// Top level of the rename and retire slice, wiring decoder, alias table and reorder buffer
`timescale 1ns/100ps
`default_nettype none

module rename_unit (
    input  logic                      clk,
    input  logic                      i_rst,
    input  logic                      i_flush,
    input  logic                      i_instr_valid,
    input  rename_cfg_pkg::instr_t    i_instr,
    input  rename_bus_pkg::cdb_t      i_cdb,
    output logic                      o_dispatch_valid,
    output rename_bus_pkg::dispatch_t o_dispatch,
    output logic                      o_stall,
    output logic                      o_illegal,
    output rename_bus_pkg::retire_t   o_retire
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    decoded_t          decoded;
    rat_lookup_t [1:0] lookup;
    operand_t [1:0]    operands;
    rob_tag_t          alloc_tag;
    logic              rename_en;

    rename_decoder rename_decoder_i (
        .i_instr   (i_instr),
        .o_decoded (decoded),
        .o_illegal (o_illegal)
    );

    reg_alias_table reg_alias_table_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_flush      (i_flush),
        .i_decoded    (decoded),
        .i_rename_en  (rename_en),
        .i_rename_tag (alloc_tag),
        .i_retire     (o_retire),
        .o_lookup     (lookup)
    );

    reorder_buffer reorder_buffer_i (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_flush          (i_flush),
        .i_valid          (i_instr_valid),
        .i_illegal        (o_illegal),
        .i_writes_rd      (decoded.writes_rd),
        .i_alloc_rd       (decoded.rd),
        .i_cdb            (i_cdb),
        .i_lookup         (lookup),
        .o_alloc_tag      (alloc_tag),
        .o_rename_en      (rename_en),
        .o_full           (o_stall),
        .o_dispatch_valid (o_dispatch_valid),
        .o_operands       (operands),
        .o_retire         (o_retire)
    );

    assign o_dispatch.tag       = alloc_tag;
    assign o_dispatch.rd        = decoded.rd;
    assign o_dispatch.writes_rd = decoded.writes_rd;
    assign o_dispatch.src       = operands;

endmodule

`default_nettype wire

//--- reorder_buffer.sv
// Reorder buffer that hands out tags, collects completions, forwards operands and retires in order
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  logic                               clk,
    input  logic                               i_rst,
    input  logic                               i_flush,
    input  logic                               i_valid,
    input  logic                               i_illegal,
    input  logic                               i_writes_rd,
    input  rename_cfg_pkg::reg_idx_t           i_alloc_rd,
    input  rename_bus_pkg::cdb_t               i_cdb,
    input  rename_bus_pkg::rat_lookup_t [1:0]  i_lookup,
    output rename_cfg_pkg::rob_tag_t           o_alloc_tag,
    output logic                               o_rename_en,
    output logic                               o_full,
    output logic                               o_dispatch_valid,
    output rename_bus_pkg::operand_t [1:0]     o_operands,
    output rename_bus_pkg::retire_t            o_retire
);

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    rob_tag_t             head;
    rob_tag_t             tail;
    rob_cnt_t             count;
    logic [ROB_DEPTH-1:0] slot_done;
    data_t                slot_data [ROB_DEPTH];
    reg_idx_t             slot_rd   [ROB_DEPTH];
    logic                 retire_fire;
    rob_tag_t             cdb_offset;
    logic                 cdb_slot_busy;

    assign o_full      = (count == rob_cnt_t'(ROB_DEPTH));
    assign o_alloc_tag = tail;

    // An instruction goes out whenever there is room and its opcode is known;
    // only those that write a register take a slot and rename their destination
    assign o_dispatch_valid = i_valid && !i_illegal && !o_full && !i_flush;
    assign o_rename_en      = o_dispatch_valid && i_writes_rd;

    // Done bits of free slots are stale, so the count qualifies the head
    assign retire_fire = (count != '0) && slot_done[head];

    assign o_retire.valid = retire_fire;
    assign o_retire.rd    = slot_rd[head];
    assign o_retire.tag   = head;
    assign o_retire.data  = slot_data[head];

    // A waiting source picks up the value of its producer once that slot is done
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (i_lookup[i].rdy) begin
                o_operands[i].rdy  = 1'b1;
                o_operands[i].data = i_lookup[i].data;
            end else begin
                o_operands[i].rdy  = slot_done[i_lookup[i].tag];
                o_operands[i].data = slot_done[i_lookup[i].tag] ?
                                     slot_data[i_lookup[i].tag] : i_lookup[i].data;
            end
            o_operands[i].tag = i_lookup[i].tag;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
        end else begin
            if (o_rename_en) begin
                tail            <= tail + 1'b1;
                slot_done[tail] <= 1'b0;
            end
            if (i_cdb.valid) begin
                slot_done[i_cdb.tag] <= 1'b1;
            end
            if (retire_fire) begin
                head <= head + 1'b1;
            end
            count <= count + rob_cnt_t'(o_rename_en) - rob_cnt_t'(retire_fire);
        end
    end

    // Slot payload
    always_ff @(posedge clk) begin
        if (o_rename_en) begin
            slot_rd[tail] <= i_alloc_rd;
        end
        if (i_cdb.valid) begin
            slot_data[i_cdb.tag] <= i_cdb.data;
        end
    end

    // Distance of the completing tag from the head tells whether it is in flight
    assign cdb_offset    = i_cdb.tag - head;
    assign cdb_slot_busy = ({1'b0, cdb_offset} < count);

    // Occupancy never exceeds the depth and always spans exactly head to tail
    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (i_rst)
        (count <= rob_cnt_t'(ROB_DEPTH)) && (tail == head + rob_tag_t'(count))
    ) else $error("reorder buffer occupancy out of step with its pointers");

    a_cdb_busy_slot: assert property (
        @(posedge clk) disable iff (i_rst)
        i_cdb.valid |-> cdb_slot_busy
    ) else $error("completion for tag %0d with no instruction in flight", i_cdb.tag);

endmodule

`default_nettype wire

//--- sim.f
rename_cfg_pkg.sv
rename_bus_pkg.sv
rename_decoder.sv
rat_entry.sv
reg_alias_table.sv
reorder_buffer.sv
rename_unit.sv
tb_rename_unit.sv

//--- tb_rename_unit.sv
// Self-checking testbench for rename_unit; run through sim.f with the Makefile
`timescale 1ns/100ps
`default_nettype none

module tb_rename_unit;

    import rename_cfg_pkg::*;
    import rename_bus_pkg::*;

    localparam int HALF_PERIOD  = 5;
    localparam int CLK_PERIOD   = 2 * HALF_PERIOD;
    localparam int RESET_CYCLES = 8;

    // Instruction classes used by the stimulus table
    localparam int K_OP     = 0;
    localparam int K_IMM    = 1;
    localparam int K_LOAD   = 2;
    localparam int K_STORE  = 3;
    localparam int K_BRANCH = 4;
    localparam int K_LUI    = 5;
    localparam int K_JAL    = 6;
    localparam int K_BAD    = 7;

    typedef struct {
        int test;
        bit valid;
        int kind;
        int rd;
        int rs1;
        int rs2;
        bit cdb_valid;
        int cdb_tag;
        bit flush;
        bit exp_stall;
        bit exp_ret;
    } stim_row_t;

    typedef struct {
        rob_tag_t tag;
        reg_idx_t rd;
        bit       done;
        data_t    data;
    } inflight_t;

    logic        clk;
    logic        i_rst;
    logic        i_flush;
    logic        i_instr_valid;
    instr_t      i_instr;
    cdb_t        i_cdb;
    logic        o_dispatch_valid;
    dispatch_t   o_dispatch;
    logic        o_stall;
    logic        o_illegal;
    retire_t     o_retire;

    // Reference model of the architectural state and the in-flight window
    data_t       reg_val [ARCH_REGS];
    rob_tag_t    reg_tag [ARCH_REGS];
    bit          reg_rdy [ARCH_REGS];
    inflight_t   inflight [$];
    int          next_tag;
    bit          exp_ret_valid;
    inflight_t   exp_ret_entry;
    bit          exp_alloc;

    stim_row_t   rows [$];
    bit          rows_ready;
    logic [31:0] rng_state;
    string       test_names [1:6];
    int          check_count;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    rename_unit dut_i (
        .clk              (clk),
        .i_rst            (i_rst),
        .i_flush          (i_flush),
        .i_instr_valid    (i_instr_valid),
        .i_instr          (i_instr),
        .i_cdb            (i_cdb),
        .o_dispatch_valid (o_dispatch_valid),
        .o_dispatch       (o_dispatch),
        .o_stall          (o_stall),
        .o_illegal        (o_illegal),
        .o_retire         (o_retire)
    );

    always #(HALF_PERIOD) clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic instr_t encode_instr(input int kind, input int rd, input int rs1,
                                            input int rs2);
        logic [6:0] opcode;
        case (kind)
            K_OP:     opcode = OPC_OP;
            K_IMM:    opcode = OPC_OP_IMM;
            K_LOAD:   opcode = OPC_LOAD;
            K_STORE:  opcode = OPC_STORE;
            K_BRANCH: opcode = OPC_BRANCH;
            K_LUI:    opcode = OPC_LUI;
            K_JAL:    opcode = OPC_JAL;
            default:  opcode = 7'b1111111;
        endcase
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opcode};
    endfunction

    // Register fields each class reads or writes, per the RISC-V formats
    function automatic bit uses_field(input int kind, input int field);
        case (field)
            0:       return kind inside {K_OP, K_IMM, K_LOAD, K_STORE, K_BRANCH};
            1:       return kind inside {K_OP, K_STORE, K_BRANCH};
            default: return kind inside {K_OP, K_IMM, K_LOAD, K_LUI, K_JAL};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [35:0] got,
                               input logic [35:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("[ERROR] %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_table_mismatch(input string what, input int idx, input bit in_table,
                                         input bit in_model);
        $display("Row %0d of the table expects %s %0b but the reference model predicts %0b",
                 idx, what, in_table, in_model);
        error_count++;
        test_errors++;
    endtask

    // A source resolves from the committed value, the retiring value or a completed slot
    task automatic predict_operand(input int src, output bit rdy, output data_t data,
                                   output rob_tag_t tag);
        rdy  = 1'b1;
        data = reg_val[src];
        tag  = reg_tag[src];
        if (src == 0) begin
            data = '0;
        end else if (!reg_rdy[src]) begin
            if (exp_ret_valid && exp_ret_entry.rd == reg_idx_t'(src) &&
                exp_ret_entry.tag == reg_tag[src]) begin
                data = exp_ret_entry.data;
            end else begin
                rdy = 1'b0;
                foreach (inflight[k]) begin
                    if (inflight[k].tag == reg_tag[src] && inflight[k].done) begin
                        rdy  = 1'b1;
                        data = inflight[k].data;
                    end
                end
            end
        end
    endtask

    task automatic check_row(input int idx);
        stim_row_t r;
        bit        stall;
        bit        dispatch;
        bit        rdy;
        data_t     data;
        rob_tag_t  tag;
        int        src;
        r             = rows[idx];
        stall         = (inflight.size() == ROB_DEPTH);
        exp_ret_valid = (inflight.size() != 0) && inflight[0].done;
        if (exp_ret_valid) begin
            exp_ret_entry = inflight[0];
        end
        assert (stall == r.exp_stall) else report_table_mismatch("stall", idx, r.exp_stall, stall);
        assert (exp_ret_valid == r.exp_ret) else
            report_table_mismatch("retire", idx, r.exp_ret, exp_ret_valid);
        check_value("o_stall", o_stall, r.exp_stall);
        check_value("o_retire.valid", o_retire.valid, r.exp_ret);
        if (exp_ret_valid) begin
            check_value("o_retire.rd", o_retire.rd, exp_ret_entry.rd);
            check_value("o_retire.tag", o_retire.tag, exp_ret_entry.tag);
            check_value("o_retire.data", o_retire.data, exp_ret_entry.data);
        end
        dispatch  = r.valid && (r.kind != K_BAD) && !stall;
        exp_alloc = dispatch && uses_field(r.kind, 2) && (r.rd != 0);
        check_value("o_dispatch_valid", o_dispatch_valid, dispatch);
        if (r.valid) begin
            check_value("o_illegal", o_illegal, r.kind == K_BAD);
        end
        if (dispatch) begin
            check_value("o_dispatch.rd", o_dispatch.rd, uses_field(r.kind, 2) ? r.rd : 0);
            check_value("o_dispatch.writes_rd", o_dispatch.writes_rd, exp_alloc);
            if (exp_alloc) begin
                check_value("o_dispatch.tag", o_dispatch.tag, next_tag);
            end
            for (int s = 0; s < 2; s++) begin
                src = uses_field(r.kind, s) ? ((s == 0) ? r.rs1 : r.rs2) : 0;
                predict_operand(src, rdy, data, tag);
                check_value($sformatf("o_dispatch.src[%0d].rdy", s), o_dispatch.src[s].rdy, rdy);
                if (rdy) begin
                    check_value($sformatf("o_dispatch.src[%0d].data", s),
                                o_dispatch.src[s].data, data);
                end else begin
                    check_value($sformatf("o_dispatch.src[%0d].tag", s),
                                o_dispatch.src[s].tag, tag);
                end
            end
        end
    endtask

    // State change of the model at the rising edge that ends the row
    task automatic commit_model(input int idx, input data_t cdb_data);
        stim_row_t r;
        int        rd;
        r = rows[idx];
        if (exp_ret_valid) begin
            rd          = int'(exp_ret_entry.rd);
            reg_val[rd] = exp_ret_entry.data;
            // A rename of the same register in this cycle keeps it waiting
            if (reg_tag[rd] == exp_ret_entry.tag && !(exp_alloc && r.rd == rd)) begin
                reg_rdy[rd] = 1'b1;
            end
            void'(inflight.pop_front());
        end
        if (r.cdb_valid) begin
            foreach (inflight[k]) begin
                if (inflight[k].tag == rob_tag_t'(r.cdb_tag)) begin
                    inflight[k].done = 1'b1;
                    inflight[k].data = cdb_data;
                end
            end
        end
        if (exp_alloc) begin
            reg_tag[r.rd] = rob_tag_t'(next_tag);
            reg_rdy[r.rd] = 1'b0;
            inflight.push_back('{rob_tag_t'(next_tag), reg_idx_t'(r.rd), 1'b0, '0});
            next_tag = (next_tag + 1) % ROB_DEPTH;
        end
        if (r.flush) begin
            inflight.delete();
            next_tag = 0;
            foreach (reg_rdy[k]) begin
                reg_rdy[k] = 1'b1;
            end
        end
    endtask

    task automatic report_test(input int test);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test, test_names[test]);
        end else begin
            $display("test %0d %s: failed with %0d errors", test, test_names[test], test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic add_row(input int test, input bit valid, input int kind, input int rd,
                           input int rs1, input int rs2, input bit cdb_valid, input int cdb_tag,
                           input bit flush, input bit exp_stall, input bit exp_ret);
        rows.push_back('{test, valid, kind, rd, rs1, rs2, cdb_valid, cdb_tag, flush,
                         exp_stall, exp_ret});
    endtask

    task automatic build_table();
        // test, valid, kind, rd, rs1, rs2, cdb valid, cdb tag, flush, stall, retire
        add_row(1, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 0);
        add_row(1, 1, K_OP,     1,  0,  0, 0, 0, 0, 0, 0);
        add_row(1, 1, K_IMM,    2,  1,  0, 0, 0, 0, 0, 0);
        add_row(1, 1, K_LUI,    3,  5,  6, 0, 0, 0, 0, 0);
        add_row(1, 1, K_STORE,  9,  2,  1, 0, 0, 0, 0, 0);
        add_row(1, 1, K_BAD,    4,  1,  2, 0, 0, 0, 0, 0);
        add_row(1, 1, K_OP,     0,  1,  3, 0, 0, 0, 0, 0);
        add_row(2, 0, K_IMM,    0,  0,  0, 1, 2, 0, 0, 0);
        add_row(2, 1, K_OP,     4,  3,  1, 0, 0, 0, 0, 0);
        add_row(2, 1, K_IMM,    5,  2,  0, 1, 1, 0, 0, 0);
        add_row(2, 1, K_BRANCH, 0,  2,  3, 0, 0, 0, 0, 0);
        add_row(3, 0, K_IMM,    0,  0,  0, 1, 4, 0, 0, 0);
        add_row(3, 0, K_IMM,    0,  0,  0, 1, 0, 0, 0, 0);
        add_row(3, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 1);
        add_row(3, 1, K_IMM,    6,  1,  0, 0, 0, 0, 0, 1);
        add_row(3, 1, K_IMM,    7,  2,  0, 0, 0, 0, 0, 1);
        add_row(3, 0, K_IMM,    0,  0,  0, 1, 3, 0, 0, 0);
        add_row(3, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 1);
        add_row(3, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 1);
        add_row(4, 0, K_IMM,    0,  0,  0, 1, 5, 0, 0, 0);
        add_row(4, 1, K_OP,     8,  6,  0, 0, 0, 0, 0, 1);
        add_row(4, 1, K_IMM,    7,  0,  0, 0, 0, 0, 0, 0);
        add_row(4, 0, K_IMM,    0,  0,  0, 1, 6, 0, 0, 0);
        add_row(4, 1, K_IMM,    7,  7,  0, 0, 0, 0, 0, 1);
        add_row(4, 1, K_OP,     9,  7,  8, 0, 0, 0, 0, 0);
        add_row(5, 1, K_IMM,   10,  0,  0, 0, 0, 0, 0, 0);
        add_row(5, 1, K_LOAD,  11, 10,  0, 0, 0, 0, 0, 0);
        add_row(5, 1, K_JAL,   12,  9,  0, 0, 0, 0, 0, 0);
        add_row(5, 1, K_IMM,   13,  0,  0, 0, 0, 0, 0, 0);
        add_row(5, 1, K_IMM,   14, 13,  0, 0, 0, 0, 1, 0);
        add_row(5, 1, K_IMM,   14, 13,  0, 1, 7, 0, 1, 0);
        add_row(5, 1, K_IMM,   14, 13,  0, 0, 0, 0, 1, 1);
        add_row(5, 1, K_IMM,   14, 13,  0, 0, 0, 0, 0, 0);
        add_row(6, 0, K_IMM,    0,  0,  0, 0, 0, 1, 1, 0);
        add_row(6, 1, K_OP,    15,  7,  6, 0, 0, 0, 0, 0);
        add_row(6, 1, K_OP,     1, 15, 14, 0, 0, 0, 0, 0);
        add_row(6, 0, K_IMM,    0,  0,  0, 1, 0, 0, 0, 0);
        add_row(6, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 1);
        add_row(6, 0, K_IMM,    0,  0,  0, 1, 1, 0, 0, 0);
        add_row(6, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 1);
        add_row(6, 0, K_IMM,    0,  0,  0, 0, 0, 0, 0, 0);
    endtask

    initial begin
        int    idx;
        data_t cdb_data;
        clk           = 1'b0;
        i_rst         = 1'b1;
        i_flush       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = encode_instr(K_IMM, 0, 0, 0);
        i_cdb         = '0;
        rng_state     = 32'hefdb3ed4;
        next_tag      = 0;
        foreach (reg_val[k]) begin
            reg_val[k] = '0;
            reg_tag[k] = '0;
            reg_rdy[k] = 1'b1;
        end
        test_names = '{"renaming", "forwarding", "in-order retire", "bypass and rename priority",
                       "back-pressure", "flush"};
        build_table();
        rows_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst <= 1'b0;
        for (idx = 0; idx < rows.size(); idx++) begin
            @(posedge clk);
            cdb_data = '0;
            if (rows[idx].cdb_valid) begin
                rng_state = next_random(rng_state);
                cdb_data  = rng_state;
            end
            i_instr_valid <= rows[idx].valid;
            i_instr       <= encode_instr(rows[idx].kind, rows[idx].rd, rows[idx].rs1,
                                          rows[idx].rs2);
            i_cdb.valid   <= rows[idx].cdb_valid;
            i_cdb.tag     <= rob_tag_t'(rows[idx].cdb_tag);
            i_cdb.data    <= cdb_data;
            i_flush       <= rows[idx].flush;
            // Outputs are settled by the falling edge
            @(negedge clk);
            check_row(idx);
            commit_model(idx, cdb_data);
            if (idx == rows.size() - 1 || rows[idx + 1].test != rows[idx].test) begin
                report_test(rows[idx].test);
            end
        end
        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Twenty cycles per table row is far beyond what a healthy run needs
    initial begin
        int limit;
        wait (rows_ready);
        limit = rows.size() * 20 * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired after %0d ns before the stimulus table finished", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
